/* src/odo_pkg.sv */
/*
 * Shared types and format constants for the odometry datapath.
 * Import with a wildcard in any module header that needs the fixed-point word.
 */
`default_nettype none

package odo_pkg;

	// ==================================================================
	// Fixed-point format |S|IIIIIIIIIIIIIIII|FFFFFFFFFFFFFFF|
	// ==================================================================

	localparam int FRAC_BITS = 15;                      // Fraction bits
	localparam int INT_BITS  = 16;                      // Integer bits
	localparam int FIX_W     = 1 + INT_BITS + FRAC_BITS; // Whole word, 32

	// Sign-magnitude word, sign set means negative
	typedef struct packed {
		logic                 sign;      // 1 = negative
		logic [INT_BITS-1:0]  int_part;  // Integer magnitude
		logic [FRAC_BITS-1:0] frac_part; // Fraction magnitude
	} fix_t;

	// ==================================================================
	// Velocity triple
	// ==================================================================

	// Same layout for body frame and global frame
	typedef struct packed {
		fix_t vx; // Linear x [m/s]
		fix_t vy; // Linear y [m/s]
		fix_t wz; // Yaw rate [rad/s]
	} vel3_t;

endpackage

`default_nettype wire

/* src/button_debounce.sv */
/*
 * Start button cleanup: two-flop synchronizer followed by a stability counter.
 * The output level only moves once the input has held still long enough.
 */
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = 1000000 // Clocks of stable input required
) (
	input  wire  clock_50,
	input  wire  arst_n,
	input  wire  button,  // Raw, bouncing, asynchronous
	output logic level    // Clean debounced level
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0]       sync_q; // Synchronizer chain
	logic [CNT_W-1:0] cnt;    // Stable-time counter

	// Metastability guard
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], button};
		end
	end

	// Counter runs only while synced input differs from the output.
	// A bounce back to the current level clears it again
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			cnt   <= '0;
			level <= 1'b0;
		end else if (sync_q[1] == level) begin
			cnt <= '0;                                    // Nothing pending
		end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
			cnt   <= '0;
			level <= sync_q[1];                           // Held long enough
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/sincos_cordic.sv */
/*
 * Rotation-mode CORDIC, angle in degrees, one iteration per clock.
 * Pulse start with theta; done pulses CORDIC_ITER+2 clocks later with sin and cos.
 */
`timescale 1ns/1ps
`default_nettype none

module sincos_cordic import odo_pkg::*; #(
	parameter int CORDIC_ITER = 16 // 12 to 20
) (
	input  wire   clock_50,
	input  wire   arst_n,
	input  wire   start,   // One-cycle pulse, ignored while busy
	input  wire   fix_t theta,
	output logic  done,    // One-cycle pulse
	output fix_t  sin_mag, // Non-negative
	output fix_t  cos_mag  // Non-negative
);

	localparam int IT_W = $clog2(CORDIC_ITER + 1);

	// 1/K for the CORDIC gain, 0.607253 in Q15
	localparam logic signed [FIX_W-1:0] K_INIT = 32'sd19898;

	// ==================================================================
	// Arctangent table, atan(2^-i) in degrees, Q15
	// ==================================================================

	function automatic logic signed [FIX_W-1:0] atan_deg(input logic [IT_W-1:0] i);
		case (i)
			0:       atan_deg = 32'sd1474560; // 45.0
			1:       atan_deg = 32'sd870484;  // 26.565
			2:       atan_deg = 32'sd459940;  // 14.036
			3:       atan_deg = 32'sd233473;  // 7.125
			4:       atan_deg = 32'sd117189;
			5:       atan_deg = 32'sd58652;
			6:       atan_deg = 32'sd29333;
			7:       atan_deg = 32'sd14667;
			8:       atan_deg = 32'sd7334;
			9:       atan_deg = 32'sd3667;
			10:      atan_deg = 32'sd1833;
			11:      atan_deg = 32'sd917;
			12:      atan_deg = 32'sd458;
			13:      atan_deg = 32'sd229;
			14:      atan_deg = 32'sd115;
			15:      atan_deg = 32'sd57;
			16:      atan_deg = 32'sd29;
			17:      atan_deg = 32'sd14;
			18:      atan_deg = 32'sd7;
			19:      atan_deg = 32'sd4;
			default: atan_deg = 32'sd0;       // Beyond useful precision
		endcase
	endfunction

	// Two's complement back to sign-magnitude, tiny negative residue clamps to zero
	function automatic fix_t to_mag(input logic signed [FIX_W-1:0] v);
		if (v[FIX_W-1])
			to_mag = '0;
		else
			to_mag = {1'b0, v[FRAC_BITS +: INT_BITS], v[FRAC_BITS-1:0]};
	endfunction

	logic                    busy;
	logic [IT_W-1:0]         it;          // Iteration index
	logic signed [FIX_W-1:0] x, y, z;     // Vector and residual angle
	logic signed [FIX_W-1:0] x_sh, y_sh;  // Scaled cross terms
	logic signed [FIX_W-1:0] theta_s;     // Signed angle at load

	assign theta_s = theta.sign ? -$signed({1'b0, theta.int_part, theta.frac_part})
	                            :  $signed({1'b0, theta.int_part, theta.frac_part});
	assign x_sh = x >>> it;
	assign y_sh = y >>> it;

	// ==================================================================
	// Control: load, iterate, finish
	// ==================================================================

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			it   <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				it   <= '0;
			end else if (busy && it != IT_W'(CORDIC_ITER)) begin
				it <= it + 1'b1;
			end else if (busy) begin
				busy <= 1'b0; // Results registered this edge
				done <= 1'b1;
			end
		end
	end

	// Datapath, shifts and adds only
	always_ff @(posedge clock_50) begin
		if (start && !busy) begin
			x <= K_INIT;  // Pre-scaled, no gain correction later
			y <= '0;
			z <= theta_s;
		end else if (busy && it != IT_W'(CORDIC_ITER)) begin
			if (!z[FIX_W-1]) begin // Residual positive, rotate forward
				x <= x - y_sh;
				y <= y + x_sh;
				z <= z - atan_deg(it);
			end else begin         // Overshot, rotate back
				x <= x + y_sh;
				y <= y - x_sh;
				z <= z + atan_deg(it);
			end
		end else if (busy) begin
			sin_mag <= to_mag(y);
			cos_mag <= to_mag(x);
		end
	end

endmodule

`default_nettype wire

/* src/sm_multiplier.sv */
/*
 * Sequential shift-add multiplier for sign-magnitude Q16.15 words.
 * Pulse start with a and b; done pulses 33 clocks later with p.
 */
`timescale 1ns/1ps
`default_nettype none

module sm_multiplier import odo_pkg::*; (
	input  wire   clock_50,
	input  wire   arst_n,
	input  wire   start,  // One-cycle pulse, ignored while busy
	input  wire   fix_t a,
	input  wire   fix_t b,
	output logic  done,   // One-cycle pulse
	output fix_t  p
);

	localparam int MAG_W = FIX_W - 1;  // 31-bit magnitudes
	localparam int ACC_W = 2 * MAG_W;  // Full-width product
	localparam int CNT_W = $clog2(MAG_W + 1);

	logic             busy;
	logic [CNT_W-1:0] cnt;      // Multiplier bits consumed
	logic [ACC_W-1:0] mcand;    // Shifted left each step
	logic [MAG_W-1:0] mplier;   // Shifted right each step
	logic [ACC_W-1:0] acc;
	logic             sign_q;
	logic [MAG_W-1:0] prod_mag; // Q15-aligned window of acc

	assign prod_mag = acc[FRAC_BITS +: MAG_W]; // Drop low fraction and high overflow

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy && cnt != CNT_W'(MAG_W)) begin
				cnt <= cnt + 1'b1;
			end else if (busy) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// One partial product per clock
	always_ff @(posedge clock_50) begin
		if (start && !busy) begin
			mcand  <= {{(ACC_W-MAG_W){1'b0}}, a.int_part, a.frac_part};
			mplier <= {b.int_part, b.frac_part};
			acc    <= '0;
			sign_q <= a.sign ^ b.sign;
		end else if (busy && cnt != CNT_W'(MAG_W)) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end else if (busy) begin
			p <= {sign_q & (|prod_mag), prod_mag}; // Zero is always positive
		end
	end

endmodule

`default_nettype wire

/* src/global_velocity.sv */
/*
 * Body-to-global velocity rotation behind a four-phase req/ack handshake.
 * Sequences one CORDIC and four products on a shared multiplier, then sums.
 */
`timescale 1ns/1ps
`default_nettype none

module global_velocity import odo_pkg::*; #(
	parameter int CORDIC_ITER = 16
) (
	input  wire    clock_50,
	input  wire    arst_n,
	input  wire    req,        // Level, rising edge starts a run
	output logic   ack,        // High from result until req drops
	input  wire    vel3_t local_vel,
	input  wire    fix_t theta, // Degrees, 0 to 90
	output vel3_t  global_vel   // Held between runs
);

	typedef enum logic [2:0] {
		S_IDLE,      // Wait for rising req
		S_TRIG,      // Kick CORDIC
		S_CORDIC,    // Wait for sin and cos
		S_MUL_START, // Kick product k
		S_MUL_WAIT,  // Wait for product k
		S_SUM,       // Combine and publish
		S_ACK        // Hold ack until req falls
	} state_t;

	state_t     state;
	logic       req_q;      // Edge detect
	logic [1:0] k;          // Product index
	vel3_t      lat_vel;    // Captured at req rise
	fix_t       lat_theta;
	fix_t       prod [0:3]; // vx*cos, vy*sin, vx*sin, vy*cos

	logic cordic_start, cordic_done;
	fix_t sin_mag, cos_mag;
	logic mul_start, mul_done;
	fix_t mul_a, mul_b, mul_p;
	fix_t sum_vx, sum_vy;

	// ==================================================================
	// Sign-magnitude adder, result sign follows the larger magnitude
	// ==================================================================

	function automatic fix_t sm_add(input fix_t a, input fix_t b);
		logic [FIX_W-2:0] ma;
		logic [FIX_W-2:0] mb;
		logic [FIX_W-2:0] mr;
		logic             sr;
		ma = {a.int_part, a.frac_part};
		mb = {b.int_part, b.frac_part};
		if (a.sign == b.sign) begin
			mr = ma + mb;            // Overflow wraps, range kept small upstream
			sr = a.sign;
		end else if (ma >= mb) begin
			mr = ma - mb;
			sr = a.sign;
		end else begin
			mr = mb - ma;
			sr = b.sign;
		end
		if (mr == '0)
			sr = 1'b0;               // No negative zero
		return {sr, mr};
	endfunction

	// ==================================================================
	// Children
	// ==================================================================

	sincos_cordic #(
		.CORDIC_ITER(CORDIC_ITER)
	) u_cordic (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.start    (cordic_start),
		.theta    (lat_theta),   // Stable for the whole run
		.done     (cordic_done),
		.sin_mag  (sin_mag),     // Held until next start
		.cos_mag  (cos_mag)
	);

	sm_multiplier u_mul (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.start    (mul_start),
		.a        (mul_a),
		.b        (mul_b),
		.done     (mul_done),
		.p        (mul_p)
	);

	assign cordic_start = (state == S_TRIG);
	assign mul_start    = (state == S_MUL_START);

	// Operand select per product slot
	always_comb begin
		case (k)
			2'd0:    begin mul_a = lat_vel.vx; mul_b = cos_mag; end
			2'd1:    begin mul_a = lat_vel.vy; mul_b = sin_mag; end
			2'd2:    begin mul_a = lat_vel.vx; mul_b = sin_mag; end
			default: begin mul_a = lat_vel.vy; mul_b = cos_mag; end
		endcase
	end

	// vx' = vx*cos - vy*sin, subtract as add with flipped sign
	assign sum_vx = sm_add(prod[0], {~prod[1].sign, prod[1].int_part, prod[1].frac_part});
	assign sum_vy = sm_add(prod[2], prod[3]); // vy' = vx*sin + vy*cos

	// ==================================================================
	// Sequencer
	// ==================================================================

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state      <= S_IDLE;
			req_q      <= 1'b0;
			k          <= 2'd0;
			ack        <= 1'b0;
			global_vel <= '0;
		end else begin
			req_q <= req;
			case (state)
				S_IDLE:      if (req && !req_q) state <= S_TRIG;
				S_TRIG:      state <= S_CORDIC;
				S_CORDIC: begin
					if (cordic_done) begin
						k     <= 2'd0;
						state <= S_MUL_START;
					end
				end
				S_MUL_START: state <= S_MUL_WAIT;
				S_MUL_WAIT: begin
					if (mul_done) begin
						k     <= k + 2'd1;
						state <= (k == 2'd3) ? S_SUM : S_MUL_START;
					end
				end
				S_SUM: begin
					global_vel <= '{vx: sum_vx, vy: sum_vy, wz: lat_vel.wz}; // wz untouched
					ack        <= 1'b1;
					state      <= S_ACK;
				end
				S_ACK: begin
					if (!req) begin  // Drops one clock after req
						ack   <= 1'b0;
						state <= S_IDLE;
					end
				end
				default:     state <= S_IDLE;
			endcase
		end
	end

	// Input capture and product store
	always_ff @(posedge clock_50) begin
		if (state == S_IDLE && req && !req_q) begin
			lat_vel   <= local_vel;
			lat_theta <= theta;
		end
		if (state == S_MUL_WAIT && mul_done)
			prod[k] <= mul_p;
	end

endmodule

`default_nettype wire

/* src/bb_system.sv */
/*
 * Board top: debounced start button drives the velocity rotation block.
 * The LEDs show sign, low integer and high fraction bits of global vx.
 */
`timescale 1ns/1ps
`default_nettype none

module bb_system import odo_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 1000000, // 20 ms at 50 MHz
	parameter int CORDIC_ITER     = 16
) (
	input  wire    clock_50,     // System clock, 50 MHz
	input  wire    arst_n,
	input  wire    start_button, // Raw push button
	input  wire    vel3_t local_vel,
	input  wire    fix_t theta,  // Degrees, 0 to 90
	output logic   ack,
	output vel3_t  global_vel,
	output logic [7:0] led
);

	logic req; // Debounced button, handshake request

	button_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_db_start (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button   (start_button),
		.level    (req)
	);

	global_velocity #(
		.CORDIC_ITER(CORDIC_ITER)
	) u_global_velocity (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.req        (req),
		.ack        (ack),
		.local_vel  (local_vel),
		.theta      (theta),
		.global_vel (global_vel)
	);

	// Sign | int[4:0] | frac[14:13]
	assign led = {global_vel.vx.sign, global_vel.vx.int_part[4:0], global_vel.vx.frac_part[14:13]};

endmodule

`default_nettype wire

/* tb/velocity_model.svh */
/*
 * Real-valued reference model for the body-to-global rotation, testbench only.
 * Included inside the testbench module, after the package import.
 */
`ifndef VELOCITY_MODEL_SVH
`define VELOCITY_MODEL_SVH

localparam real SCALE   = 32768.0;                   // 2^FRAC_BITS
localparam real TOL     = 1.0 / 64.0;                // 2^-6 per component
localparam real DEG2RAD = 3.14159265358979 / 180.0;

// Sign-magnitude word to real
function automatic real fix_to_real(input fix_t f);
	real mag;
	mag = $itor({1'b0, f.int_part, f.frac_part}) / SCALE;
	return f.sign ? -mag : mag;
endfunction

// Nearest word, zero stays positive
function automatic fix_t real_to_fix(input real r);
	real         a;
	int unsigned mag;
	fix_t        f;
	a   = (r < 0.0) ? -r : r;
	mag = $rtoi(a * SCALE + 0.5);
	{f.int_part, f.frac_part} = mag[FIX_W-2:0];
	f.sign = (r < 0.0) && (mag != 0);
	return f;
endfunction

// Rotation by theta in degrees
function automatic real rotate_x(input real vx, input real vy, input real th);
	return vx * $cos(th * DEG2RAD) - vy * $sin(th * DEG2RAD);
endfunction

function automatic real rotate_y(input real vx, input real vy, input real th);
	return vx * $sin(th * DEG2RAD) + vy * $cos(th * DEG2RAD);
endfunction

// Absolute error against the bound
function automatic bit within_tol(input real got, input real expected);
	return ((got > expected) ? got - expected : expected - got) <= TOL;
endfunction

`endif

/* tb/tb_bb_system.sv */
/*
 * Testbench for the odometry top: reset, debounce, directed and random rotations.
 * Immediate assertions compare each result with the real-valued model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_bb_system import odo_pkg::*; ();

	`include "velocity_model.svh"

	localparam int          DEBOUNCE_CYCLES = 8;
	localparam int          ACK_TIMEOUT     = 1000; // Debounce plus one full run, with margin
	localparam int          N_RANDOM        = 40;
	localparam logic [15:0] BOUNCE          = 16'b0110_1110_1011_0111; // Runs of 1 below 8

	logic        clock_50;
	logic        arst_n;
	logic        start_button;
	vel3_t       local_vel;
	fix_t        theta;
	logic        ack;
	vel3_t       global_vel;
	logic [7:0]  led;
	vel3_t       v;
	vel3_t       held;    // Result kept across the bounce
	fix_t        th;
	int unsigned seed;

	bb_system #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.CORDIC_ITER    (16)
	) UUT (
		.clock_50     (clock_50),
		.arst_n       (arst_n),
		.start_button (start_button),
		.local_vel    (local_vel),
		.theta        (theta),
		.ack          (ack),
		.global_vel   (global_vel),
		.led          (led)
	);

	always #10 clock_50 = ~clock_50; // 20 ns period

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	// Poll on rising edges until ack reaches level
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level) begin
			@(posedge clock_50);
			n++;
			if (n > ACK_TIMEOUT)
				fail_now($sformatf("Timeout: ack did not reach %0d within %0d cycles",
					level, ACK_TIMEOUT));
		end
	endtask

	task automatic expect_ack_steady(input logic level, input int n);
		repeat (n) begin
			@(posedge clock_50);
			assert (ack === level)
				else fail_now($sformatf("ack left level %0d too early", level));
		end
	endtask

	task automatic press(input vel3_t vin, input fix_t thin);
		@(posedge clock_50);
		local_vel    <= vin;
		theta        <= thin;
		start_button <= 1'b1;
		wait_ack(1'b1);
	endtask

	task automatic release_button();
		@(posedge clock_50);
		start_button <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic check_axis(input string name, input fix_t got, input real expected);
		assert (within_tol(fix_to_real(got), expected))
			else fail_now($sformatf("MISMATCH %s got 0x%h expected 0x%h",
				name, got, real_to_fix(expected)));
	endtask

	// Rotated axes, wz pass-through and LED map
	task automatic check_result(input vel3_t lv, input real ex, input real ey);
		logic [7:0]  led_exp;
		real         vx_r;
		int unsigned quarters;
		check_axis("global_vel.vx", global_vel.vx, ex);
		check_axis("global_vel.vy", global_vel.vy, ey);
		assert (global_vel.wz === lv.wz) else fail_now($sformatf(
			"MISMATCH global_vel.wz got 0x%h expected 0x%h", global_vel.wz, lv.wz));
		// LEDs show |vx| in quarter units, modulo 128, under the sign
		vx_r     = fix_to_real(global_vel.vx);
		quarters = $rtoi(((vx_r < 0.0) ? -vx_r : vx_r) * 4.0);
		led_exp  = {global_vel.vx.sign, quarters[6:0]};
		assert (led === led_exp) else fail_now($sformatf(
			"MISMATCH led got 0x%h expected 0x%h", led, led_exp));
	endtask

	task automatic run_case(input vel3_t vin, input fix_t thin, input real ex, input real ey);
		press(vin, thin);
		check_result(vin, ex, ey);
		release_button();
	endtask

	function automatic fix_t rand_fix(input int unsigned int_max);
		fix_t f;
		f.sign      = $urandom_range(1);
		f.int_part  = $urandom_range(int_max);
		f.frac_part = $urandom_range(32767);
		return f;
	endfunction

	function automatic fix_t rand_theta();
		int unsigned mag;
		mag = $urandom_range(90 * 32768); // 0 to 90 degrees inclusive
		return {1'b0, mag[FIX_W-2:0]};
	endfunction

	initial begin
		clock_50     = 1'b0;
		arst_n       = 1'b0;
		start_button = 1'b0;
		local_vel    = '0;
		theta        = '0;
		seed         = 32'h2ddb;
		void'($urandom(seed));
		repeat (3) @(posedge clock_50);
		arst_n <= 1'b1;
		@(posedge clock_50);

		// ==================================================================
		// Reset state, debounce delay, ack held with the button
		// ==================================================================
		assert (ack === 1'b0 && global_vel === '0)
			else fail_now("Reset did not clear ack or global_vel");

		// Steady press one cycle short of the debounce time
		@(posedge clock_50);
		start_button <= 1'b1;
		repeat (DEBOUNCE_CYCLES - 1) @(posedge clock_50);
		start_button <= 1'b0;
		expect_ack_steady(1'b0, ACK_TIMEOUT);

		v = '{vx: real_to_fix(12.5), vy: real_to_fix(-3.25), wz: real_to_fix(-2.5)};
		press(v, '0);
		check_result(v, fix_to_real(v.vx), fix_to_real(v.vy));
		expect_ack_steady(1'b1, 20);
		release_button();

		// Short bouncing pulse, new inputs must not be taken
		held = global_vel;
		@(posedge clock_50);
		local_vel <= ~held;
		for (int i = 15; i >= 0; i--) begin
			@(posedge clock_50);
			start_button <= BOUNCE[i];
			assert (ack === 1'b0) else fail_now("ack rose on a bouncing pulse");
		end
		@(posedge clock_50);
		start_button <= 1'b0;
		expect_ack_steady(1'b0, ACK_TIMEOUT);
		assert (global_vel === held) else fail_now($sformatf(
			"MISMATCH global_vel got 0x%h expected 0x%h", global_vel, held));

		// ==================================================================
		// Directed corners, 0 and 90 degrees
		// ==================================================================
		th = '{sign: 1'b0, int_part: 16'd90, frac_part: '0};
		run_case(v, th, -fix_to_real(v.vy), fix_to_real(v.vx));
		v = '{vx: real_to_fix(-20.75), vy: real_to_fix(7.125), wz: real_to_fix(0.5)};
		run_case(v, '0, fix_to_real(v.vx), fix_to_real(v.vy));
		run_case(v, th, -fix_to_real(v.vy), fix_to_real(v.vx));

		// Random triples, mixed signs
		for (int i = 0; i < N_RANDOM; i++) begin
			v  = '{vx: rand_fix(31), vy: rand_fix(31), wz: rand_fix(16'hffff)};
			th = rand_theta();
			run_case(v, th,
				rotate_x(fix_to_real(v.vx), fix_to_real(v.vy), fix_to_real(th)),
				rotate_y(fix_to_real(v.vx), fix_to_real(v.vy), fix_to_real(th)));
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
src/odo_pkg.sv
src/button_debounce.sv
src/sincos_cordic.sv
src/sm_multiplier.sv
src/global_velocity.sv
src/bb_system.sv
tb/tb_bb_system.sv
